// ==== test/routerInput.txt ====
# name lenL lenN lenE lenW lenS readyMode enable order cntL cntN cntE cntW cntS
# lengths count the header (0 = no packet), readyMode 1 = random outReady, counts are totals
singleS      0  0 0 0 6 0 1 S     0 0 0 0 1
allPorts     2  3 4 5 9 0 1 LNEWS 1 1 1 1 2
rotation     3  0 4 6 0 0 1 LEW   2 1 2 2 2
wrapAround   5  2 0 0 7 0 1 SLN   3 2 2 2 3
backPressure 4  7 2 3 5 1 1 EWSLN 4 3 3 3 4
disabled     0  3 0 4 0 0 0 WN    4 4 3 4 4
longMixed    12 0 8 0 0 1 1 EL    5 4 4 4 4

// ==== sources.f ====
src/routerPkg.sv
src/flitFifo.sv
src/packetTimer.sv
src/outputArbiter.sv
src/outputMux.sv
src/apbRegs.sv
src/routerOutputPort.sv
test/portChecker.sv
test/routerTb.sv

// ==== test/routerTb.sv ====
module routerTb
  import routerPkg::*;
();

  localparam int maxTests = 16;
  localparam int maxLen = 32;
  localparam int holdCycles = 30; // quiet window while arbitration is off.

  logic clk;
  logic rst;
  logic [numPorts-1:0] inValid;
  logic [numPorts-1:0][flitWidth-1:0] inFlit;
  logic [numPorts-1:0] inReady;
  logic outValid;
  logic [flitWidth-1:0] outFlit;
  logic outReady;
  logic psel;
  logic penable;
  logic pwrite;
  logic [7:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic drained;
  int failCount;

  // one entry per line of the data file.
  logic [8*16-1:0] testName [maxTests];
  logic [8*8-1:0] orderStr [maxTests];
  int pktLen [maxTests][numPorts];
  int expCount [maxTests][numPorts];
  int readyMode [maxTests];
  int enableVal [maxTests];
  logic [flitWidth-1:0] pktFlits [numPorts][maxLen];
  int numTests;
  int totalFlits;
  int cycleLimit;
  int cycles;
  logic [31:0] seed;
  logic loaded;

  routerOutputPort dut0 (.clk(clk), .rst(rst), .inValid(inValid), .inFlit(inFlit),
    .inReady(inReady), .outValid(outValid), .outFlit(outFlit), .outReady(outReady),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready));

  portChecker check0 (.clk(clk), .rst(rst), .outValid(outValid), .outReady(outReady),
    .outFlit(outFlit), .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .prdata(prdata), .pready(pready), .drained(drained), .failCount(failCount));

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int portOf(input logic [7:0] c);
    case (c)
      "L": return portL;
      "N": return portN;
      "E": return portE;
      "W": return portW;
      "S": return portS;
      default: return -1;
    endcase
  endfunction

  task automatic loadTests();
    int fd;
    int code;
    int n;
    logic [8*200-1:0] skipLine;
    fd = $fopen("test/routerInput.txt", "r");
    loaded = (fd != 0);
    numTests = 0;
    totalFlits = 0;
    if (loaded)
    begin
      code = $fgets(skipLine, fd); // two column lines.
      code = $fgets(skipLine, fd);
      code = 14;
      while (code == 14 && numTests < maxTests)
      begin
        n = numTests;
        code = $fscanf(fd, "%s %d %d %d %d %d %d %d %s %d %d %d %d %d", testName[n],
          pktLen[n][0], pktLen[n][1], pktLen[n][2], pktLen[n][3], pktLen[n][4],
          readyMode[n], enableVal[n], orderStr[n], expCount[n][0], expCount[n][1],
          expCount[n][2], expCount[n][3], expCount[n][4]);
        if (code == 14)
        begin
          for (int i = 0; i < numPorts; i++)
            totalFlits += pktLen[n][i];
          numTests++;
        end
      end
      $fclose(fd);
    end
    loaded = loaded && (numTests > 0);
    cycleLimit = 20 * totalFlits + 200;
  endtask

  // header carries the length, then bodies, then the tail.
  task automatic makeFlits(input int t);
    int len;
    for (int p = 0; p < numPorts; p++)
    begin
      len = pktLen[t][p];
      pktFlits[p][0] = {idHeader, 1'b0, lengthWidth'(len)};
      for (int k = 1; k < len; k++)
      begin
        seed = xorshift(seed);
        pktFlits[p][k] = {(k == len - 1) ? idTail : idBody, seed[12:0]};
      end
    end
  endtask

  task automatic queueExpected(input int t);
    int p;
    for (int j = 7; j >= 0; j--)
    begin
      p = portOf(orderStr[t][8*j +: 8]);
      if (p >= 0)
        for (int k = 0; k < pktLen[t][p]; k++)
          check0.expectFlit(p, pktFlits[p][k]);
    end
    for (int i = 0; i < numPorts; i++)
      check0.expectCount(i, expCount[t][i]);
  endtask

  task automatic stepReady(input int t);
    if (readyMode[t] != 0)
    begin
      seed = xorshift(seed);
      outReady = seed[7];
    end
    else
      outReady = 1'b1;
  endtask

  task automatic injectPackets(input int t);
    int sent [numPorts];
    logic [numPorts-1:0] accepted;
    logic busy;
    accepted = '0;
    busy = 1'b1;
    for (int i = 0; i < numPorts; i++)
      sent[i] = 0;
    while (busy)
    begin
      busy = 1'b0;
      for (int i = 0; i < numPorts; i++)
      begin
        if (accepted[i])
          sent[i]++;
        inValid[i] = (sent[i] < pktLen[t][i]);
        if (inValid[i])
          inFlit[i] = pktFlits[i][sent[i]];
        accepted[i] = inValid[i] && inReady[i]; // inReady holds until the next rising edge.
        busy = busy || inValid[i];
      end
      stepReady(t);
      if (busy)
        @(negedge clk);
    end
  endtask

  task automatic waitDrained(input int t);
    while (!drained)
    begin
      stepReady(t);
      @(negedge clk);
    end
    outReady = 1'b1;
  endtask

  task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic readReg(input logic [7:0] addr);
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic runTest(input int t);
    makeFlits(t);
    check0.beginTest(testName[t], enableVal[t]);
    queueExpected(t);
    writeReg(addrCtrl, 32'(enableVal[t]));
    readReg(addrCtrl);
    if (enableVal[t] == 0)
      check0.setQuiet(1'b1);
    injectPackets(t);
    if (enableVal[t] == 0)
    begin
      repeat (holdCycles) @(negedge clk);
      check0.setQuiet(1'b0);
      writeReg(addrCtrl, 32'd1);
    end
    waitDrained(t);
    for (int i = 0; i < numPorts; i++)
      readReg(addrCount0 + 8'(4 * i));
    check0.endTest();
  endtask

  initial
  begin
    rst = 1'b1;
    inValid = '0;
    inFlit = '0;
    outReady = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    seed = 32'h45b8;
    loadTests();
    if (!loaded)
    begin
      $display("could not read any test from test/routerInput.txt");
      $display("SIMULATION FAILED");
      $finish;
    end
    else
    begin
      repeat (4) @(negedge clk);
      rst = 1'b0;
      for (int t = 0; t < numTests; t++)
        runTest(t);
      check0.printCounts();
      if (failCount == 0)
        $display("SIMULATION PASSED");
      else
        $display("SIMULATION FAILED");
      $finish;
    end
  end

  // run limit scales with the flits in the data file.
  initial
  begin
    cycles = 0;
    @(posedge clk);
    while (cycles < cycleLimit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles", cycles);
    check0.reportStuck();
    check0.printCounts();
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== test/portChecker.sv ====
module portChecker
  import routerPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 outValid,
  input  logic                 outReady,
  input  logic [flitWidth-1:0] outFlit,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [7:0]           paddr,
  input  logic [31:0]          prdata,
  input  logic                 pready,
  output logic                 drained,
  output int                   failCount
);

  logic [8*16-1:0] testName = "reset";
  logic [flitWidth-1:0] expFlits [$]; // whole output sequence of the test.
  int expPorts [$];
  int expCtrl = 0;
  int expCount [numPorts];
  int pending = 0;
  int testErrors = 0;
  int testFlits = 0;
  int errors = 0;
  int testsRun = 0;
  int testsFailed = 0;
  logic quiet = 1'b0;
  logic [flitWidth-1:0] wantFlit;
  int wantPort;
  logic [31:0] wantRead;

  assign drained = (pending == 0);
  assign failCount = errors;

  function automatic logic [31:0] expectedRead(input logic [7:0] addr);
    logic [31:0] value;
    value = '0;
    if (addr == addrCtrl)
      value = 32'(expCtrl);
    for (int i = 0; i < numPorts; i++)
      if (addr == addrCount0 + 8'(4 * i))
        value = 32'(expCount[i]);
    return value;
  endfunction

  task beginTest(input logic [8*16-1:0] name, input int ctrl);
    testName = name;
    expCtrl = ctrl;
    testErrors = 0;
    testFlits = 0;
  endtask

  task expectFlit(input int port, input logic [flitWidth-1:0] flit);
    expFlits.push_back(flit);
    expPorts.push_back(port);
    pending++;
  endtask

  task expectCount(input int port, input int value);
    expCount[port] = value;
  endtask

  task setQuiet(input logic q);
    quiet = q;
  endtask

  task endTest();
    testsRun++;
    if (testErrors == 0)
      $display("test %0s passed, %0d flits", testName, testFlits);
    else
    begin
      testsFailed++;
      $display("test %0s failed with %0d errors", testName, testErrors);
    end
  endtask

  task reportStuck();
    if (pending > 0)
      $display("test %0s hung: the packet from port %0d never finished, %0d flits missing",
        testName, expPorts[0], pending);
    else
      $display("test %0s hung before its register reads finished", testName);
    errors++;
    testsRun++;
    testsFailed++;
  endtask

  task printCounts();
    $display("tests run %0d, passed %0d, failed %0d, errors %0d", testsRun,
      testsRun - testsFailed, testsFailed, errors);
  endtask

  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (quiet && outValid)
      begin
        $display("test %0s: a packet started while arbitration was disabled", testName);
        quiet = 1'b0;
        testErrors++;
        errors++;
      end
      if (outValid && outReady)
      begin
        if (pending == 0)
        begin
          $display("test %0s: flit %h arrived with no packet expected", testName, outFlit);
          testErrors++;
          errors++;
        end
        else
        begin
          wantFlit = expFlits.pop_front();
          wantPort = expPorts.pop_front();
          pending--;
          testFlits++;
          if (outFlit !== wantFlit)
          begin
            $display("error %0s: port %0d flit expected %h actual %h", testName, wantPort,
              wantFlit, outFlit);
            testErrors++;
            errors++;
          end
        end
      end
      // read data is valid in the access phase.
      if (psel && penable && !pwrite)
      begin
        wantRead = expectedRead(paddr);
        if (prdata !== wantRead)
        begin
          $display("error %0s: read at %h expected %h actual %h", testName, paddr, wantRead,
            prdata);
          testErrors++;
          errors++;
        end
      end
      if (psel && penable && pready !== 1'b1)
      begin
        $display("error %0s: pready expected 1 actual %b", testName, pready);
        testErrors++;
        errors++;
      end
    end
  end

endmodule

// ==== src/routerOutputPort.sv ====
module routerOutputPort
  import routerPkg::*;
(
  input  logic                               clk,
  input  logic                               rst,
  input  logic [numPorts-1:0]                inValid,
  input  logic [numPorts-1:0][flitWidth-1:0] inFlit,
  output logic [numPorts-1:0]                inReady,
  output logic                               outValid,
  output logic [flitWidth-1:0]               outFlit,
  input  logic                               outReady,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [7:0]                         paddr,
  input  logic [31:0]                        pwdata,
  output logic [31:0]                        prdata,
  output logic                               pready
);

  logic [numPorts-1:0] push;
  logic [numPorts-1:0] full;
  logic [numPorts-1:0] notEmpty;
  logic [numPorts-1:0][flitWidth-1:0] headFlits;
  logic [numPorts-1:0] pop;
  logic [numPorts-1:0] lastFlit;
  logic [numPorts-1:0] grant;
  logic [numPorts-1:0] packetDone;
  logic enable;

  assign inReady = ~full;
  assign push = inValid & inReady;

  for (genvar i = 0; i < numPorts; i++)
  begin : gPort
    flitFifo queue (.clk(clk), .rst(rst), .push(push[i]), .pushFlit(inFlit[i]),
      .pop(pop[i]), .headFlit(headFlits[i]), .notEmpty(notEmpty[i]), .full(full[i]));

    packetTimer pktTimer (.clk(clk), .rst(rst), .pop(pop[i]), .headFlit(headFlits[i]),
      .lastFlit(lastFlit[i]));
  end

  outputArbiter arbiter (.clk(clk), .rst(rst), .enable(enable), .notEmpty(notEmpty),
    .pop(pop), .lastFlit(lastFlit), .grant(grant), .packetDone(packetDone));

  outputMux mux (.clk(clk), .rst(rst), .grant(grant), .notEmpty(notEmpty),
    .headFlits(headFlits), .outReady(outReady), .pop(pop), .outValid(outValid),
    .outFlit(outFlit));

  apbRegs regs (.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .packetDone(packetDone), .enable(enable));

endmodule

// ==== src/apbRegs.sv ====
module apbRegs
  import routerPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [7:0]          paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  input  logic [numPorts-1:0] packetDone,
  output logic                enable
);

  logic [countWidth-1:0] pktCount [numPorts];
  logic [31:0] readData;

  assign pready = 1'b1; // no wait states.

  always_ff @(posedge clk)
  begin
    if (rst)
      enable <= 1'b0;
    else if (psel && penable && pwrite && paddr == addrCtrl)
      enable <= pwdata[0];
  end

  // counters stick at all ones.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < numPorts; i++)
        pktCount[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < numPorts; i++)
        if (packetDone[i] && pktCount[i] != '1)
          pktCount[i] <= pktCount[i] + 1'b1;
    end
  end

  always_comb
  begin
    readData = '0;
    if (paddr == addrCtrl)
      readData = {31'b0, enable};
    for (int i = 0; i < numPorts; i++)
      if (paddr == addrCount0 + 8'(4 * i))
        readData = 32'(pktCount[i]);
  end

  // sampled in setup, so it is ready for the access phase.
  always_ff @(posedge clk)
  begin
    if (rst)
      prdata <= '0;
    else if (psel && !penable && !pwrite)
      prdata <= readData;
  end

endmodule

// ==== src/outputMux.sv ====
module outputMux
  import routerPkg::*;
(
  input  logic                               clk,
  input  logic                               rst,
  input  logic [numPorts-1:0]                grant,
  input  logic [numPorts-1:0]                notEmpty,
  input  logic [numPorts-1:0][flitWidth-1:0] headFlits,
  input  logic                               outReady,
  output logic [numPorts-1:0]                pop,
  output logic                               outValid,
  output logic [flitWidth-1:0]               outFlit
);

  logic [flitWidth-1:0] selFlit;
  logic loadOk;

  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < numPorts; i++)
      if (grant[i])
        selFlit = headFlits[i];
  end

  assign loadOk = !outValid || outReady; // register empty or being drained.
  assign pop = grant & notEmpty & {numPorts{loadOk}};

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (|pop)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
      outFlit <= selFlit;
  end

  assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> (outValid && $stable(outFlit)))
    else $error("outputMux: output changed while stalled");

endmodule

// ==== src/outputArbiter.sv ====
module outputArbiter
  import routerPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                enable,
  input  logic [numPorts-1:0] notEmpty,
  input  logic [numPorts-1:0] pop,
  input  logic [numPorts-1:0] lastFlit,
  output logic [numPorts-1:0] grant,
  output logic [numPorts-1:0] packetDone
);

  // a holding state carries the holder's port index.
  typedef enum logic [2:0] {
    holdL = 3'(portL),
    holdN = 3'(portN),
    holdE = 3'(portE),
    holdW = 3'(portW),
    holdS = 3'(portS),
    idle = 3'd7
  } stateT;

  stateT state;
  stateT nextState;
  stateT prevHolder;

  // first requester after the given port, wrapping round; idle if none.
  function automatic stateT pickNext(input logic [numPorts-1:0] req, input logic [2:0] after);
    stateT pick;
    int idx;
    pick = idle;
    for (int k = numPorts; k >= 1; k--)
    begin
      idx = (int'(after) + k) % numPorts;
      if (req[idx])
        pick = stateT'(idx);
    end
    return pick;
  endfunction

  always_comb
  begin
    for (int i = 0; i < numPorts; i++)
      grant[i] = (state == stateT'(i));
  end

  assign packetDone = pop & lastFlit & grant;

  always_comb
  begin
    nextState = state;
    if (state == idle)
    begin
      if (enable)
        nextState = pickNext(notEmpty, prevHolder);
    end
    else if (|packetDone)
    begin
      // the holder may be draining its only flit, so it is skipped here.
      if (enable)
        nextState = pickNext(notEmpty & ~grant, state);
      else
        nextState = idle;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= idle;
      prevHolder <= holdS; // so the first grant after reset starts at L.
    end
    else
    begin
      state <= nextState;
      if (state != idle)
        prevHolder <= state;
    end
  end

  assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("outputArbiter: more than one grant");

endmodule

// ==== src/packetTimer.sv ====
module packetTimer
  import routerPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 pop,
  input  logic [flitWidth-1:0] headFlit,
  output logic                 lastFlit
);

  logic [flitIdWidth-1:0] headId;
  logic [lengthWidth-1:0] pktLength;
  logic [lengthWidth-1:0] count; // zero means idle.

  assign headId = headFlit[flitWidth-1 -: flitIdWidth];
  assign lastFlit = pop && (count != '0) && (count + 1'b1 == pktLength);

  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (pop)
    begin
      if (headId == idHeader)
        count <= 1; // header is flit one.
      else if (lastFlit)
        count <= '0;
      else if (count != '0)
        count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop && headId == idHeader)
      pktLength <= headFlit[lengthWidth-1:0];
  end

  assert property (@(posedge clk) disable iff (rst) (pop && headId == idHeader) |-> count == '0)
    else $error("packetTimer: header popped inside a packet");

  // the announced length must agree with where the sender put the tail.
  assert property (@(posedge clk) disable iff (rst)
    (pop && count != '0) |-> headId == (lastFlit ? idTail : idBody))
    else $error("packetTimer: flit id does not match the header length");

endmodule

// ==== src/flitFifo.sv ====
module flitFifo
  import routerPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push,
  input  logic [flitWidth-1:0] pushFlit,
  input  logic                 pop,
  output logic [flitWidth-1:0] headFlit,
  output logic                 notEmpty,
  output logic                 full
);

  logic [flitWidth-1:0] mem [fifoDepth];
  logic [$clog2(fifoDepth)-1:0] rdPtr;
  logic [$clog2(fifoDepth)-1:0] wrPtr;
  logic [$clog2(fifoDepth+1)-1:0] used;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      used <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == fifoDepth - 1) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == fifoDepth - 1) ? '0 : rdPtr + 1'b1;
      if (push && !pop)
        used <= used + 1'b1;
      else if (pop && !push)
        used <= used - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= pushFlit;
  end

  // head is read straight from the array.
  assign headFlit = mem[rdPtr];
  assign notEmpty = (used != '0);
  assign full = (used == fifoDepth);

  // input side gates push with inReady, the mux gates pop with notEmpty.
  assert property (@(posedge clk) disable iff (rst) !(push && full) && !(pop && !notEmpty))
    else $error("flitFifo: push while full or pop while empty");

endmodule

// ==== src/routerPkg.sv ====
package routerPkg;

  // router inputs, in rotation order.
  localparam int numPorts = 5;
  localparam int portL = 0;
  localparam int portN = 1;
  localparam int portE = 2;
  localparam int portW = 3;
  localparam int portS = 4;

  // flit layout is {id, body}.
  localparam int flitWidth = 16;
  localparam int flitIdWidth = 3;
  localparam int lengthWidth = 12; // header length field, counts the header too.

  // one-hot flit identifiers.
  localparam logic [flitIdWidth-1:0] idHeader = 3'b001;
  localparam logic [flitIdWidth-1:0] idBody = 3'b010;
  localparam logic [flitIdWidth-1:0] idTail = 3'b100;

  localparam int fifoDepth = 4;

  // APB map.
  localparam logic [7:0] addrCtrl = 8'h00;   // bit 0 is the enable.
  localparam logic [7:0] addrCount0 = 8'h04; // one counter per port, 4 bytes apart.
  localparam int countWidth = 16;

endpackage
